// ==== compile.f ====
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/writeback_stage.sv
hdl/mycpu_top.sv
verif/tb_mycpu.sv

// ==== Bender.yml ====
package:
  name: mycpu

sources:
  - hdl/isa_pkg.sv
  - hdl/pipe_pkg.sv
  - hdl/fetch_stage.sv
  - hdl/decode_stage.sv
  - hdl/execute_stage.sv
  - hdl/writeback_stage.sv
  - hdl/mycpu_top.sv
  - target: simulation
    files:
      - verif/tb_mycpu.sv

// ==== verif/tb_mycpu.sv ====
`timescale 1ns/1ps
// testbench for the four-stage MIPS core
// runs a short program without and with fetch stalls and checks the golden trace
module tb_mycpu;
    import pipe_pkg::*;
    import isa_pkg::*;

    localparam int NUM_ROWS     = 28;
    localparam int RUN_TIMEOUT  = 400;  // cycles per pass
    localparam int DRAIN_CYCLES = 20;
    localparam int RESET_CYCLES = 16;

    logic       aclk = 1'b0;
    logic       reset;
    logic       inst_busy;
    word_t      inst_rdata;
    word_t      inst_addr;
    word_t      debug_wb_pc;
    word_t      debug_wb_rf_wdata;
    logic [3:0] debug_wb_rf_wen;
    reg_idx_t   debug_wb_rf_wnum;

    logic        stall_en = 1'b0;
    logic [31:0] rng = 32'hab3f;

    // program table, one row per instruction word
    word_t    prog_instr [NUM_ROWS];
    logic     exp_write  [NUM_ROWS];
    reg_idx_t exp_reg    [NUM_ROWS];
    word_t    exp_val    [NUM_ROWS];
    int       num_filled = 0;

    mycpu_top mycpu_top_i (.*);

    always #20 aclk = ~aclk;  // 40 ns period

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic word_t enc_r(input funct_e fn, input reg_idx_t rd,
                                    input reg_idx_t rs, input reg_idx_t rt);
        return {OPC_SPECIAL, rs, rt, rd, 5'b00000, fn};
    endfunction

    function automatic word_t enc_i(input opcode_e op, input reg_idx_t rt,
                                    input reg_idx_t rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // instruction memory, words past the table read as a no-op
    function automatic word_t read_imem(input word_t addr);
        word_t offset;
        offset = (addr - RESET_PC) >> 2;
        if (offset < NUM_ROWS) begin
            return prog_instr[offset];
        end
        return '0;
    endfunction

    assign inst_rdata = read_imem(inst_addr);

    // random fetch stalls in the second pass
    always @(posedge aclk) begin
        if (stall_en) begin
            rng = xorshift32(rng);
        end
        inst_busy <= stall_en && rng[0];
    end

    task automatic add_row(input word_t instr, input logic we, input reg_idx_t dst,
                           input word_t val);
        prog_instr[num_filled] = instr;
        exp_write[num_filled]  = we;
        exp_reg[num_filled]    = dst;
        exp_val[num_filled]    = val;
        num_filled++;
    endtask

    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("Finished with errors");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic compare_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            stop_with_error($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic compare_reg(input string name, input reg_idx_t got, input reg_idx_t exp);
        if (got !== exp) begin
            stop_with_error($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
        end
    endtask

    function automatic int next_write(input int from);
        for (int i = from; i < NUM_ROWS; i++) begin
            if (exp_write[i]) begin
                return i;
            end
        end
        return NUM_ROWS;
    endfunction

    task automatic apply_reset(input logic with_stalls);
        int n;
        @(posedge aclk);
        reset    <= 1'b1;
        stall_en <= with_stalls;
        for (n = 0; n < RESET_CYCLES; n++) begin
            @(negedge aclk);
            if (n > 0) begin
                if (debug_wb_rf_wen !== 4'b0000) begin
                    stop_with_error("a trace write appeared while reset was held");
                end
                compare_word("inst_addr", inst_addr, RESET_PC);  // boot vector in reset
            end
            @(posedge aclk);
        end
        reset <= 1'b0;
    endtask

    task automatic run_program();
        int idx;
        int cycles;
        idx    = next_write(0);
        cycles = 0;
        while (idx < NUM_ROWS) begin
            @(negedge aclk);  // trace is stable mid-cycle
            cycles++;
            if (cycles > RUN_TIMEOUT) begin
                stop_with_error($sformatf("timeout waiting for the write of row %0d", idx));
            end
            if (debug_wb_rf_wen == TRACE_WEN_ON) begin
                compare_word("debug_wb_pc", debug_wb_pc, RESET_PC + word_t'(4 * idx));
                compare_reg("debug_wb_rf_wnum", debug_wb_rf_wnum, exp_reg[idx]);
                compare_word("debug_wb_rf_wdata", debug_wb_rf_wdata, exp_val[idx]);
                idx = next_write(idx + 1);
            end else if (debug_wb_rf_wen !== 4'b0000) begin
                stop_with_error("trace byte enable was neither all on nor all off");
            end
        end
        // only no-ops follow the last row
        for (cycles = 0; cycles < DRAIN_CYCLES; cycles++) begin
            @(negedge aclk);
            if (debug_wb_rf_wen !== 4'b0000) begin
                stop_with_error("an unexpected trace write appeared after the program");
            end
        end
    endtask

    initial begin
        reset     <= 1'b1;
        inst_busy <= 1'b0;
        // instruction, write expected, register, value
        add_row(enc_i(OPC_LUI, 5'd1, 5'd0, 16'h1234), 1'b1, 5'd1, 32'h12340000);
        add_row(enc_i(OPC_ORI, 5'd1, 5'd1, 16'h5678), 1'b1, 5'd1, 32'h12345678);
        add_row(enc_i(OPC_ADDIU, 5'd2, 5'd0, 16'hffff), 1'b1, 5'd2, 32'hffffffff);
        add_row(enc_r(FN_ADDU, 5'd3, 5'd1, 5'd2), 1'b1, 5'd3, 32'h12345677);
        add_row(enc_r(FN_SUBU, 5'd4, 5'd3, 5'd1), 1'b1, 5'd4, 32'hffffffff);
        add_row(enc_r(FN_AND, 5'd5, 5'd1, 5'd3), 1'b1, 5'd5, 32'h12345670);
        add_row(enc_i(OPC_ORI, 5'd6, 5'd0, 16'h80f0), 1'b1, 5'd6, 32'h000080f0);
        add_row(enc_r(FN_OR, 5'd7, 5'd6, 5'd5), 1'b1, 5'd7, 32'h1234d6f0);
        add_row(enc_r(FN_SLT, 5'd8, 5'd2, 5'd6), 1'b1, 5'd8, 32'h00000001);
        add_row(enc_r(FN_SLT, 5'd9, 5'd6, 5'd2), 1'b1, 5'd9, 32'h00000000);
        add_row(enc_i(OPC_ADDIU, 5'd0, 5'd0, 16'h0055), 1'b0, 5'd0, 32'h0);  // r0 not written
        add_row(enc_r(FN_ADDU, 5'd10, 5'd0, 5'd6), 1'b1, 5'd10, 32'h000080f0);
        add_row(enc_i(OPC_BEQ, 5'd1, 5'd1, 16'd2), 1'b0, 5'd0, 32'h0);  // taken to row 15
        add_row(enc_i(OPC_ADDIU, 5'd11, 5'd0, 16'd1), 1'b0, 5'd0, 32'h0);
        add_row(enc_i(OPC_ADDIU, 5'd11, 5'd0, 16'd2), 1'b0, 5'd0, 32'h0);
        add_row(enc_i(OPC_BNE, 5'd9, 5'd8, 16'd2), 1'b0, 5'd0, 32'h0);  // taken to row 18
        add_row(enc_i(OPC_ADDIU, 5'd12, 5'd0, 16'd3), 1'b0, 5'd0, 32'h0);
        add_row(enc_i(OPC_ADDIU, 5'd12, 5'd0, 16'd4), 1'b0, 5'd0, 32'h0);
        add_row(enc_i(OPC_BEQ, 5'd9, 5'd8, 16'd5), 1'b0, 5'd0, 32'h0);  // not taken
        add_row(enc_i(OPC_BNE, 5'd3, 5'd3, 16'd5), 1'b0, 5'd0, 32'h0);  // not taken
        add_row(enc_i(OPC_ADDIU, 5'd13, 5'd10, 16'h7fff), 1'b1, 5'd13, 32'h000100ef);
        add_row(enc_i(OPC_ADDIU, 5'd14, 5'd13, 16'h8000), 1'b1, 5'd14, 32'h000080ef);
        add_row(enc_r(FN_SUBU, 5'd15, 5'd0, 5'd14), 1'b1, 5'd15, 32'hffff7f11);
        add_row(enc_r(FN_SLT, 5'd16, 5'd15, 5'd0), 1'b1, 5'd16, 32'h00000001);
        add_row(enc_i(OPC_ADDIU, 5'd17, 5'd0, 16'd7), 1'b1, 5'd17, 32'h00000007);
        add_row(enc_i(OPC_BNE, 5'd0, 5'd17, 16'd1), 1'b0, 5'd0, 32'h0);  // forwarded operand
        add_row(enc_i(OPC_ADDIU, 5'd18, 5'd0, 16'd9), 1'b0, 5'd0, 32'h0);
        add_row(enc_r(FN_ADDU, 5'd19, 5'd17, 5'd16), 1'b1, 5'd19, 32'h00000008);

        apply_reset(1'b0);
        run_program();
        apply_reset(1'b1);  // same trace expected under stalls
        run_program();

        $display("Finished with no errors");
        $finish;
    end

endmodule

// ==== hdl/mycpu_top.sv ====
`timescale 1ns/1ps
// four-stage in-order MIPS core top level
module mycpu_top (
    input  logic               aclk,
    input  logic               reset,
    input  logic               inst_busy,
    input  pipe_pkg::word_t    inst_rdata,
    output pipe_pkg::word_t    inst_addr,
    output pipe_pkg::word_t    debug_wb_pc,
    output pipe_pkg::word_t    debug_wb_rf_wdata,
    output logic [3:0]         debug_wb_rf_wen,
    output pipe_pkg::reg_idx_t debug_wb_rf_wnum
);
    import pipe_pkg::*;

    // fetch to decode
    logic     id_valid;
    word_t    id_pc;
    word_t    id_instr;

    // decode to execute
    logic     ex_valid;
    word_t    ex_pc;
    alu_op_e  ex_op;
    reg_idx_t ex_rs;
    reg_idx_t ex_rt;
    reg_idx_t ex_dst;
    word_t    ex_a;
    word_t    ex_b;
    logic     ex_b_is_imm;
    word_t    ex_target;

    // branch redirect from execute
    logic     branch_taken;
    word_t    branch_target;

    // execute to writeback
    logic     res_valid;
    word_t    res_pc;
    reg_idx_t res_dst;
    word_t    res_data;

    // writeback to regfile and bypass
    logic     wb_we;
    reg_idx_t wb_dst;
    word_t    wb_data;

    // every port matches a wire or top-level port of the same name
    fetch_stage u_fetch_stage (.*);

    decode_stage u_decode_stage (.*);

    execute_stage u_execute_stage (.*);

    writeback_stage u_writeback_stage (.*);

endmodule

// ==== hdl/writeback_stage.sv ====
`timescale 1ns/1ps
// writeback stage, drives the register-file write port
// and mirrors each retiring write onto the golden trace
module writeback_stage (
    input  logic               aclk,
    input  logic               reset,
    input  logic               res_valid,
    input  pipe_pkg::word_t    res_pc,
    input  pipe_pkg::reg_idx_t res_dst,
    input  pipe_pkg::word_t    res_data,
    output logic               wb_we,
    output pipe_pkg::reg_idx_t wb_dst,
    output pipe_pkg::word_t    wb_data,
    output pipe_pkg::word_t    debug_wb_pc,
    output pipe_pkg::word_t    debug_wb_rf_wdata,
    output logic [3:0]         debug_wb_rf_wen,
    output pipe_pkg::reg_idx_t debug_wb_rf_wnum
);
    import pipe_pkg::*;

    word_t wb_pc;

    always_ff @(posedge aclk) begin
        if (reset) begin
            wb_we <= 1'b0;
        end else begin
            wb_we <= res_valid && (res_dst != '0);  // r0 writes dropped here
        end
    end

    always_ff @(posedge aclk) begin
        wb_pc   <= res_pc;
        wb_dst  <= res_dst;
        wb_data <= res_data;
    end

    assign debug_wb_pc       = wb_pc;
    assign debug_wb_rf_wdata = wb_data;
    assign debug_wb_rf_wen   = wb_we ? TRACE_WEN_ON : 4'b0000;
    assign debug_wb_rf_wnum  = wb_dst;

endmodule

// ==== hdl/execute_stage.sv ====
`timescale 1ns/1ps
// execute stage, forwards the writeback result into the operands
// computes the alu result and resolves branches
module execute_stage (
    input  logic               ex_valid,
    input  pipe_pkg::word_t    ex_pc,
    input  pipe_pkg::alu_op_e  ex_op,
    input  pipe_pkg::reg_idx_t ex_rs,
    input  pipe_pkg::reg_idx_t ex_rt,
    input  pipe_pkg::reg_idx_t ex_dst,
    input  pipe_pkg::word_t    ex_a,
    input  pipe_pkg::word_t    ex_b,
    input  logic               ex_b_is_imm,
    input  pipe_pkg::word_t    ex_target,
    input  logic               wb_we,
    input  pipe_pkg::reg_idx_t wb_dst,
    input  pipe_pkg::word_t    wb_data,
    output logic               branch_taken,
    output pipe_pkg::word_t    branch_target,
    output logic               res_valid,
    output pipe_pkg::word_t    res_pc,
    output pipe_pkg::reg_idx_t res_dst,
    output pipe_pkg::word_t    res_data
);
    import pipe_pkg::*;

    word_t op_a;
    word_t op_b;
    word_t alu_res;
    logic  equal;
    logic  writes_reg;

    assign op_a = (wb_we && ex_rs != '0 && wb_dst == ex_rs) ? wb_data : ex_a;
    // immediate operands never take the bypass
    assign op_b = (!ex_b_is_imm && wb_we && ex_rt != '0 && wb_dst == ex_rt) ? wb_data : ex_b;

    always_comb begin
        case (ex_op)
            ALU_ADD: alu_res = op_a + op_b;
            ALU_SUB: alu_res = op_a - op_b;
            ALU_AND: alu_res = op_a & op_b;
            ALU_OR:  alu_res = op_a | op_b;
            ALU_SLT: alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_LUI: alu_res = op_b;  // already shifted in decode
            default: alu_res = '0;
        endcase
    end

    assign equal = (op_a == op_b);

    assign branch_taken = ex_valid &&
                          ((ex_op == ALU_BEQ && equal) || (ex_op == ALU_BNE && !equal));
    assign branch_target = ex_target;

    assign writes_reg = (ex_op != ALU_BEQ) && (ex_op != ALU_BNE) && (ex_op != ALU_NONE);

    assign res_valid = ex_valid;
    assign res_pc    = ex_pc;
    assign res_dst   = writes_reg ? ex_dst : '0;
    assign res_data  = alu_res;

endmodule

// ==== hdl/decode_stage.sv ====
`timescale 1ns/1ps
// decode stage with the register file
// turns the instruction into an operation and operands for execute
module decode_stage (
    input  logic               aclk,
    input  logic               reset,
    input  logic               id_valid,
    input  pipe_pkg::word_t    id_pc,
    input  pipe_pkg::word_t    id_instr,
    input  logic               branch_taken,
    input  logic               wb_we,
    input  pipe_pkg::reg_idx_t wb_dst,
    input  pipe_pkg::word_t    wb_data,
    output logic               ex_valid,
    output pipe_pkg::word_t    ex_pc,
    output pipe_pkg::alu_op_e  ex_op,
    output pipe_pkg::reg_idx_t ex_rs,
    output pipe_pkg::reg_idx_t ex_rt,
    output pipe_pkg::reg_idx_t ex_dst,
    output pipe_pkg::word_t    ex_a,
    output pipe_pkg::word_t    ex_b,
    output logic               ex_b_is_imm,
    output pipe_pkg::word_t    ex_target
);
    import pipe_pkg::*;
    import isa_pkg::*;

    opcode_e  opcode;
    funct_e   funct;
    reg_idx_t rs;
    reg_idx_t rt;
    reg_idx_t rd;
    word_t    imm_sext;
    word_t    imm_zext;
    word_t    imm_upper;
    alu_op_e  dec_op;
    reg_idx_t dec_dst;
    word_t    dec_imm;
    logic     dec_b_is_imm;
    word_t    rs_val;
    word_t    rt_val;
    word_t    regs [NUM_REGS];

    assign opcode    = opcode_e'(id_instr[OPCODE_LSB +: 6]);
    assign funct     = funct_e'(id_instr[5:0]);
    assign rs        = id_instr[RS_LSB +: 5];
    assign rt        = id_instr[RT_LSB +: 5];
    assign rd        = id_instr[RD_LSB +: 5];
    assign imm_sext  = {{(32 - IMM_WIDTH){id_instr[IMM_WIDTH-1]}}, id_instr[IMM_WIDTH-1:0]};
    assign imm_zext  = {{(32 - IMM_WIDTH){1'b0}}, id_instr[IMM_WIDTH-1:0]};
    assign imm_upper = {id_instr[IMM_WIDTH-1:0], {(32 - IMM_WIDTH){1'b0}}};

    always_comb begin
        dec_op       = ALU_NONE;
        dec_dst      = '0;  // zero means no write
        dec_b_is_imm = 1'b0;
        dec_imm      = imm_sext;
        case (opcode)
            OPC_SPECIAL: begin
                dec_dst = rd;
                case (funct)
                    FN_ADDU: dec_op = ALU_ADD;
                    FN_SUBU: dec_op = ALU_SUB;
                    FN_AND:  dec_op = ALU_AND;
                    FN_OR:   dec_op = ALU_OR;
                    FN_SLT:  dec_op = ALU_SLT;
                    default: dec_dst = '0;  // unknown funct is a no-op
                endcase
            end
            OPC_ADDIU: begin
                dec_op       = ALU_ADD;
                dec_dst      = rt;
                dec_b_is_imm = 1'b1;
            end
            OPC_ORI: begin
                dec_op       = ALU_OR;
                dec_dst      = rt;
                dec_b_is_imm = 1'b1;
                dec_imm      = imm_zext;
            end
            OPC_LUI: begin
                dec_op       = ALU_LUI;
                dec_dst      = rt;
                dec_b_is_imm = 1'b1;
                dec_imm      = imm_upper;
            end
            OPC_BEQ: dec_op = ALU_BEQ;
            OPC_BNE: dec_op = ALU_BNE;
            default: dec_op = ALU_NONE;
        endcase
    end

    // register file, a write in this cycle is seen by the read
    always_ff @(posedge aclk) begin
        if (wb_we && wb_dst != '0) begin
            regs[wb_dst] <= wb_data;
        end
    end

    assign rs_val = (rs == '0) ? '0 : (wb_we && wb_dst == rs) ? wb_data : regs[rs];
    assign rt_val = (rt == '0) ? '0 : (wb_we && wb_dst == rt) ? wb_data : regs[rt];

    always_ff @(posedge aclk) begin
        if (reset) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= id_valid && !branch_taken;  // squash the younger one
        end
    end

    always_ff @(posedge aclk) begin
        ex_pc       <= id_pc;
        ex_op       <= dec_op;
        ex_rs       <= rs;
        ex_rt       <= rt;
        ex_dst      <= dec_dst;
        ex_a        <= rs_val;
        ex_b        <= dec_b_is_imm ? dec_imm : rt_val;
        ex_b_is_imm <= dec_b_is_imm;
        ex_target   <= id_pc + 32'd4 + {imm_sext[29:0], 2'b00};  // no delay slot
    end

endmodule

// ==== hdl/fetch_stage.sv ====
`timescale 1ns/1ps
// fetch stage, holds the pc and drives the instruction port
// captures the returned word into the fetch/decode register
module fetch_stage (
    input  logic            aclk,
    input  logic            reset,
    input  logic            inst_busy,
    input  logic            branch_taken,
    input  pipe_pkg::word_t branch_target,
    input  pipe_pkg::word_t inst_rdata,
    output pipe_pkg::word_t inst_addr,
    output logic            id_valid,
    output pipe_pkg::word_t id_pc,
    output pipe_pkg::word_t id_instr
);
    import pipe_pkg::*;

    word_t pc;
    logic  accept;  // instruction taken this cycle

    assign inst_addr = pc;
    assign accept    = !inst_busy && !branch_taken;  // redirect beats a stall

    always_ff @(posedge aclk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else if (branch_taken) begin
            pc <= branch_target;
        end else if (accept) begin
            pc <= pc + 32'd4;
        end
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            id_valid <= 1'b0;
        end else begin
            id_valid <= accept;  // bubble when stalled or squashed
        end
    end

    always_ff @(posedge aclk) begin
        if (accept) begin
            id_pc    <= pc;
            id_instr <= inst_rdata;
        end
    end

endmodule

// ==== hdl/pipe_pkg.sv ====
// pipeline-wide types and constants
// data word, register index, execute operation and reset values
package pipe_pkg;

    typedef logic [31:0] word_t;     // data, pc or instruction
    typedef logic [4:0]  reg_idx_t;  // gpr number

    // operation carried from decode into execute
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_LUI,   // passes the shifted immediate
        ALU_BEQ,
        ALU_BNE,
        ALU_NONE   // bubble or unknown opcode
    } alu_op_e;

    localparam word_t RESET_PC = 32'hbfc00000;  // boot vector

    localparam int NUM_REGS = 32;

    // golden trace byte enable for a writing instruction
    localparam logic [3:0] TRACE_WEN_ON = 4'b1111;

endpackage

// ==== hdl/isa_pkg.sv ====
// MIPS instruction encoding for the integer subset of the core
// major opcodes, R-type function codes and instruction field positions
package isa_pkg;

    // field positions inside a 32-bit instruction word
    localparam int OPCODE_LSB = 26;
    localparam int RS_LSB     = 21;
    localparam int RT_LSB     = 16;
    localparam int RD_LSB     = 11;
    localparam int IMM_WIDTH  = 16;  // lower half holds the immediate

    // major opcodes, bits 31:26
    typedef enum logic [5:0] {
        OPC_SPECIAL = 6'h00,  // r-type, operation in funct
        OPC_BEQ     = 6'h04,
        OPC_BNE     = 6'h05,
        OPC_ADDIU   = 6'h09,
        OPC_ORI     = 6'h0d,
        OPC_LUI     = 6'h0f
    } opcode_e;

    // r-type function codes, bits 5:0
    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_SLT  = 6'h2a   // signed compare
    } funct_e;

endpackage
